//--- common/ed_alu_macros.svh
`ifndef ED_ALU_MACROS_SVH
`define ED_ALU_MACROS_SVH

// Width of one element of GF(q)
`define ED_FIELD_W 255

// Field prime q = 2^255 - 19
`define ED_Q 255'h7fffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffed

// Twisted Edwards constant d = -121665/121666 mod q
`define ED_D 255'h52036cee_2b6ffe73_8cc74079_7779e898_00700a4d_4141d8ab_75eb4dca_135978a3

// Operation codes on in_op
`define ED_OP_PRECAL 1'b0 // b - a, a + b, t * d
`define ED_OP_DIVMUL 1'b1 // r * X, r * Y, forced even

`endif

//--- common/ed_alu_pkg.sv
`default_nettype none

`include "ed_alu_macros.svh"

package ed_alu_pkg;

	// Field element, always kept below q at module boundaries
	typedef logic [`ED_FIELD_W-1:0] fe_t;

	// Full integer product before reduction
	typedef logic [2*`ED_FIELD_W-1:0] prod_t;

	typedef logic [0:0] op_t; // Matches the ED_OP_* codes

	typedef enum logic [1:0] {
		IDLE,
		PRE_CAL,
		DIVMUL
	} alu_state_t;

	typedef logic [1:0] step_t; // Position inside an operation

	// Multiplier operand pair: 0 t*d, 1 r*x, 2 r*y
	typedef logic [1:0] mul_sel_t;

	// out_x source: 0 diff, 1 sum, 2 unregistered product, 3 even product
	typedef logic [1:0] out_sel_t;

endpackage

`default_nettype wire

//--- ed_alu/alu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ed_alu_macros.svh"

module alu_sequencer (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 in_valid,
	input  ed_alu_pkg::op_t      in_op,
	output ed_alu_pkg::mul_sel_t mul_sel,
	output ed_alu_pkg::out_sel_t x_sel,
	output logic                 neg_odd,
	output logic                 x_we,
	output logic                 y_we,
	output logic                 t_we,
	output logic                 ready
);

	ed_alu_pkg::alu_state_t state;
	ed_alu_pkg::alu_state_t state_nxt;
	ed_alu_pkg::step_t      step;
	ed_alu_pkg::step_t      step_nxt;
	logic                   last;

	assign last = (state == ed_alu_pkg::PRE_CAL && step == 2'd1) ||
		(state == ed_alu_pkg::DIVMUL && step == 2'd3);

	always_comb begin
		state_nxt = state;
		case (state)
			ed_alu_pkg::IDLE: begin
				if (in_valid) begin
					state_nxt = (in_op == `ED_OP_DIVMUL) ? ed_alu_pkg::DIVMUL : ed_alu_pkg::PRE_CAL;
				end
			end
			default: begin
				if (last) begin
					state_nxt = ed_alu_pkg::IDLE;
				end
			end
		endcase
	end

	// Counter restarts on every new operation
	assign step_nxt = (state == ed_alu_pkg::IDLE || last) ? 2'd0 : step + 2'd1;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ed_alu_pkg::IDLE;
			step  <= 2'd0;
		end else begin
			state <= state_nxt;
			step  <= step_nxt;
		end
	end

	// Per-step decode
	always_comb begin
		mul_sel = 2'd0;
		x_sel   = 2'd0;
		neg_odd = 1'b0;
		x_we    = 1'b0;
		y_we    = 1'b0;
		t_we    = 1'b0;
		case (state)
			ed_alu_pkg::PRE_CAL: begin
				case (step)
					2'd0: begin
						x_we = 1'b1; // b - a
						y_we = 1'b1; // a + b
					end
					default: t_we = 1'b1; // t * d from result_now
				endcase
			end
			ed_alu_pkg::DIVMUL: begin
				x_sel   = 2'd3;
				neg_odd = 1'b1;
				case (step)
					2'd0:    mul_sel = 2'd1; // Issue r * X
					2'd1:    mul_sel = 2'd2; // Issue r * Y
					2'd2:    x_we = 1'b1;
					default: y_we = 1'b1;
				endcase
			end
			default: ;
		endcase
	end

	assign ready = last;

	a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
		ready |=> state == ed_alu_pkg::IDLE && !(x_we || y_we || t_we));

	a_precal_ready: assert property (@(posedge clk) disable iff (rst)
		state == ed_alu_pkg::IDLE && in_valid && in_op == `ED_OP_PRECAL
		|=> !ready ##1 ready);

	a_divmul_ready: assert property (@(posedge clk) disable iff (rst)
		state == ed_alu_pkg::IDLE && in_valid && in_op == `ED_OP_DIVMUL
		|=> !ready ##1 !ready ##1 !ready ##1 ready);

endmodule

`default_nettype wire

//--- ed_alu/ed_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ed_alu_macros.svh"

module ed_alu (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid,
	input  ed_alu_pkg::op_t   in_op,
	input  ed_alu_pkg::fe_t   in_a,
	input  ed_alu_pkg::fe_t   in_b,
	input  ed_alu_pkg::fe_t   in_t,
	input  ed_alu_pkg::fe_t   in_r,
	input  ed_alu_pkg::fe_t   in_x,
	input  ed_alu_pkg::fe_t   in_y,
	output ed_alu_pkg::fe_t   out_x,
	output ed_alu_pkg::fe_t   out_y,
	output ed_alu_pkg::fe_t   out_t,
	output logic              x_we,
	output logic              y_we,
	output logic              t_we,
	output logic              ready
);

	ed_alu_pkg::mul_sel_t mul_sel;
	ed_alu_pkg::out_sel_t x_sel;
	logic                 neg_odd;
	ed_alu_pkg::fe_t      mul_a;
	ed_alu_pkg::fe_t      mul_b;
	ed_alu_pkg::prod_t    product;
	ed_alu_pkg::fe_t      result_now;
	ed_alu_pkg::fe_t      result_reg;
	ed_alu_pkg::fe_t      sub_a;
	ed_alu_pkg::fe_t      sub_b;
	ed_alu_pkg::fe_t      sum;
	ed_alu_pkg::fe_t      diff;
	ed_alu_pkg::fe_t      prod_even;

	alu_sequencer i_seq (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_op    (in_op),
		.mul_sel  (mul_sel),
		.x_sel    (x_sel),
		.neg_odd  (neg_odd),
		.x_we     (x_we),
		.y_we     (y_we),
		.t_we     (t_we),
		.ready    (ready)
	);

	// Multiplier operand pairs
	always_comb begin
		case (mul_sel)
			2'd1: begin
				mul_a = in_r;
				mul_b = in_x;
			end
			2'd2: begin
				mul_a = in_r;
				mul_b = in_y;
			end
			default: begin
				mul_a = in_t; // Pre-calculation t * d
				mul_b = `ED_D;
			end
		endcase
	end

	mod_mul i_mul (
		.clk     (clk),
		.rst     (rst),
		.a       (mul_a),
		.b       (mul_b),
		.product (product)
	);

	mod_reduce i_reduce (
		.clk        (clk),
		.rst        (rst),
		.product    (product),
		.result_now (result_now),
		.result_reg (result_reg)
	);

	// Subtractor turns into q - result_reg for the parity fix
	assign sub_a = neg_odd ? `ED_Q : in_b;
	assign sub_b = neg_odd ? result_reg : in_a;

	mod_add_sub i_add_sub (
		.a_add (in_a),
		.b_add (in_b),
		.a_sub (sub_a),
		.b_sub (sub_b),
		.sum   (sum),
		.diff  (diff)
	);

	assign prod_even = result_reg[0] ? diff : result_reg; // Odd results are negated

	always_comb begin
		case (x_sel)
			2'd0:    out_x = diff;
			2'd1:    out_x = sum;
			2'd2:    out_x = result_now;
			default: out_x = prod_even;
		endcase
	end

	assign out_y = neg_odd ? prod_even : sum;
	assign out_t = result_now; // Only t * d lands here

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/ed_alu_pkg.sv
logic/mod_mul.sv
logic/mod_reduce.sv
logic/mod_add_sub.sv
ed_alu/alu_sequencer.sv
ed_alu/ed_alu.sv
test/clk_gen.sv
test/tb_ed_alu.sv

//--- logic/mod_add_sub.sv
`timescale 1ns/1ps
`default_nettype none

`include "ed_alu_macros.svh"

module mod_add_sub (
	input  ed_alu_pkg::fe_t a_add,
	input  ed_alu_pkg::fe_t b_add,
	input  ed_alu_pkg::fe_t a_sub,
	input  ed_alu_pkg::fe_t b_sub,
	output ed_alu_pkg::fe_t sum,
	output ed_alu_pkg::fe_t diff
);

	logic [`ED_FIELD_W:0] sum_raw;
	logic [`ED_FIELD_W:0] sum_red;
	logic [`ED_FIELD_W:0] diff_raw;
	logic [`ED_FIELD_W:0] diff_fix;

	// Sum below 2q, one conditional subtract
	assign sum_raw = {1'b0, a_add} + {1'b0, b_add};
	assign sum_red = sum_raw - {1'b0, `ED_Q};
	assign sum     = sum_red[`ED_FIELD_W] ? sum_raw[`ED_FIELD_W-1:0] : sum_red[`ED_FIELD_W-1:0];

	// Borrow out of the difference brings q back in
	assign diff_raw = {1'b0, a_sub} - {1'b0, b_sub};
	assign diff_fix = diff_raw + {1'b0, `ED_Q};
	assign diff     = diff_raw[`ED_FIELD_W] ? diff_fix[`ED_FIELD_W-1:0] :
		diff_raw[`ED_FIELD_W-1:0];

endmodule

`default_nettype wire

//--- logic/mod_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "ed_alu_macros.svh"

module mod_mul (
	input  logic              clk,
	input  logic              rst,
	input  ed_alu_pkg::fe_t   a,
	input  ed_alu_pkg::fe_t   b,
	output ed_alu_pkg::prod_t product
);

	ed_alu_pkg::prod_t full;

	// Plain integer product, reduction happens downstream
	assign full = {{`ED_FIELD_W{1'b0}}, a} * {{`ED_FIELD_W{1'b0}}, b};

	always_ff @(posedge clk) begin
		if (rst) begin
			product <= '0;
		end else begin
			product <= full;
		end
	end

endmodule

`default_nettype wire

//--- logic/mod_reduce.sv
`timescale 1ns/1ps
`default_nettype none

`include "ed_alu_macros.svh"

module mod_reduce (
	input  logic              clk,
	input  logic              rst,
	input  ed_alu_pkg::prod_t product,
	output ed_alu_pkg::fe_t   result_now,
	output ed_alu_pkg::fe_t   result_reg
);

	logic [`ED_FIELD_W+4:0] fold1; // lo + 19 * hi, below 20 * 2^255
	logic [9:0]             hi1_x19;
	logic [`ED_FIELD_W:0]   fold2; // Below 2q
	logic [`ED_FIELD_W:0]   fold2_sub;

	// 2^255 = 19 mod q, so the high half folds back with weight 19
	assign fold1 = {5'd0, product[`ED_FIELD_W-1:0]} +
		{5'd0, product[2*`ED_FIELD_W-1:`ED_FIELD_W]} * {{`ED_FIELD_W{1'b0}}, 5'd19};

	// Second fold, only five high bits remain
	assign hi1_x19 = {5'd0, fold1[`ED_FIELD_W+4:`ED_FIELD_W]} * 10'd19;
	assign fold2   = {1'b0, fold1[`ED_FIELD_W-1:0]} + {{(`ED_FIELD_W-9){1'b0}}, hi1_x19};

	// Top bit set means fold2 was already below q
	assign fold2_sub  = fold2 - {1'b0, `ED_Q};
	assign result_now = fold2_sub[`ED_FIELD_W] ? fold2[`ED_FIELD_W-1:0] :
		fold2_sub[`ED_FIELD_W-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			result_reg <= '0;
		end else begin
			result_reg <= result_now;
		end
	end

	a_reg_below_q: assert property (@(posedge clk) disable iff (rst)
		result_reg < `ED_Q);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the ed_alu testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f list.f --top-module tb_ed_alu -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi
exit 0

//--- test/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	output logic clk
);

	// 40 ns period, first rising edge at 20 ns
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

endmodule

`default_nettype wire

//--- test/tb_ed_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ed_alu_macros.svh"

module tb_ed_alu;

	localparam int N_RAND = 200;
	localparam int N_EDGE = 18;
	localparam int TIMEOUT_CYCLES = 2000; // 218 ops at up to 7 cycles, reset and idle checks

	logic            clk;
	logic            rst;
	logic            in_valid;
	ed_alu_pkg::op_t in_op;
	ed_alu_pkg::fe_t in_a;
	ed_alu_pkg::fe_t in_b;
	ed_alu_pkg::fe_t in_t;
	ed_alu_pkg::fe_t in_r;
	ed_alu_pkg::fe_t in_x;
	ed_alu_pkg::fe_t in_y;
	ed_alu_pkg::fe_t out_x;
	ed_alu_pkg::fe_t out_y;
	ed_alu_pkg::fe_t out_t;
	logic            x_we;
	logic            y_we;
	logic            t_we;
	logic            ready;
	int              checks;
	int              value_errors;
	int              other_errors;
	int              cycle_count;

	clk_gen i_clk (.clk(clk));

	ed_alu i_dut (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_op    (in_op),
		.in_a     (in_a),
		.in_b     (in_b),
		.in_t     (in_t),
		.in_r     (in_r),
		.in_x     (in_x),
		.in_y     (in_y),
		.out_x    (out_x),
		.out_y    (out_y),
		.out_t    (out_t),
		.x_we     (x_we),
		.y_we     (y_we),
		.t_we     (t_we),
		.ready    (ready)
	);

	// Reference model on 512-bit integers
	function automatic ed_alu_pkg::fe_t mod_q(input logic [511:0] v);
		logic [511:0] rem;
		rem = v % {257'd0, `ED_Q};
		return rem[254:0];
	endfunction

	function automatic ed_alu_pkg::fe_t model_mul(input ed_alu_pkg::fe_t a, input ed_alu_pkg::fe_t b);
		return mod_q({257'd0, a} * {257'd0, b});
	endfunction

	function automatic ed_alu_pkg::fe_t model_add(input ed_alu_pkg::fe_t a, input ed_alu_pkg::fe_t b);
		return mod_q({257'd0, a} + {257'd0, b});
	endfunction

	function automatic ed_alu_pkg::fe_t model_sub(input ed_alu_pkg::fe_t a, input ed_alu_pkg::fe_t b);
		return mod_q({257'd0, a} + {257'd0, `ED_Q} - {257'd0, b}); // a - b
	endfunction

	function automatic ed_alu_pkg::fe_t make_even(input ed_alu_pkg::fe_t v);
		return v[0] ? `ED_Q - v : v;
	endfunction

	function automatic ed_alu_pkg::fe_t rand_fe();
		logic [255:0] v;
		for (int k = 0; k < 8; k++) begin
			v[k*32 +: 32] = $urandom;
		end
		return mod_q({257'd0, v[254:0]});
	endfunction

	function automatic ed_alu_pkg::fe_t edge_val(input int k);
		case (k % 3)
			0:       return '0;
			1:       return 255'd1;
			default: return `ED_Q - 255'd1;
		endcase
	endfunction

	task automatic check_fe(input string name, input ed_alu_pkg::fe_t got, input ed_alu_pkg::fe_t exp);
		checks++;
		assert (got == exp) else begin
			value_errors++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_int(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			value_errors++;
			$display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			other_errors++;
			$display("error at %0t ns: %s", $time, what);
		end
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(posedge clk);
			#5;
			in_valid = 1'b0;
			@(negedge clk);
			check_true(!(ready || x_we || y_we || t_we), "ready or a write enable is high while idle");
		end
	endtask

	task automatic run_op(
		input ed_alu_pkg::op_t op,
		input ed_alu_pkg::fe_t a,
		input ed_alu_pkg::fe_t b,
		input ed_alu_pkg::fe_t t,
		input ed_alu_pkg::fe_t r,
		input ed_alu_pkg::fe_t x,
		input ed_alu_pkg::fe_t y,
		input bit              mid_pulse
	);
		ed_alu_pkg::fe_t got_x;
		ed_alu_pkg::fe_t got_y;
		ed_alu_pkg::fe_t got_t;
		int              n_x;
		int              n_y;
		int              n_t;
		int              n;
		bit              divmul;
		divmul = (op == `ED_OP_DIVMUL);
		n_x = 0;
		n_y = 0;
		n_t = 0;
		n = 0;
		got_x = '0;
		got_y = '0;
		got_t = '0;
		@(posedge clk);
		#5;
		in_op = op;
		in_a = a;
		in_b = b;
		in_t = t;
		in_r = r;
		in_x = x;
		in_y = y;
		in_valid = 1'b1;
		do begin
			@(posedge clk);
			#5;
			in_valid = mid_pulse && (n == 1); // Must be ignored while busy
			@(negedge clk);
			n++;
			if (x_we) begin
				n_x++;
				got_x = out_x;
			end
			if (y_we) begin
				n_y++;
				got_y = out_y;
			end
			if (t_we) begin
				n_t++;
				got_t = out_t;
			end
		end while (!ready && n < 8);
		check_true(ready, "ready did not arrive within 8 cycles");
		check_int("ready latency", n, divmul ? 4 : 2);
		check_int("x_we pulses", n_x, 1);
		check_int("y_we pulses", n_y, 1);
		if (divmul) begin
			check_int("t_we pulses", n_t, 0);
			check_fe("out_x", got_x, make_even(model_mul(r, x)));
			check_fe("out_y", got_y, make_even(model_mul(r, y)));
			check_true(!got_x[0] && !got_y[0], "division-multiply result is odd");
		end else begin
			check_int("t_we pulses", n_t, 1);
			check_fe("out_x", got_x, model_sub(b, a));
			check_fe("out_y", got_y, model_add(a, b));
			check_fe("out_t", got_t, model_mul(t, `ED_D));
		end
		idle_cycles(1);
	endtask

	initial begin
		ed_alu_pkg::fe_t ra;
		ed_alu_pkg::fe_t rb;
		int unsigned     rnd;
		rnd = $urandom(32'h2855);
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_op = '0;
		in_a = '0;
		in_b = '0;
		in_t = '0;
		in_r = '0;
		in_x = '0;
		in_y = '0;
		repeat (4) @(posedge clk);
		#5;
		rst = 1'b0;
		idle_cycles(8); // Quiet outputs before the first start

		// Operands from 0, 1 and q - 1, with a = b every fourth op
		for (int i = 0; i < N_EDGE; i++) begin
			run_op(i[0], edge_val(i), (i % 4 == 3) ? edge_val(i) : edge_val(i / 3),
				edge_val(i / 2), edge_val(i / 4), edge_val(i + 1), edge_val(i / 5), i % 5 == 0);
		end

		for (int i = 0; i < N_RAND; i++) begin
			rnd = $urandom;
			ra = rand_fe();
			rb = (rnd[7:5] == 3'd0) ? ra : rand_fe();
			run_op(rnd[0], ra, rb, rand_fe(), rand_fe(), rand_fe(), rand_fe(), rnd[4:2] == 3'd0);
			if (rnd[1]) begin
				idle_cycles(1);
			end
		end

		$display("checks %0d, mismatches %0d, other errors %0d", checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		other_errors++;
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("checks %0d, mismatches %0d, other errors %0d", checks, value_errors, other_errors);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
